//--- Bender.yml
package:
  name: dram_sched

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/dram_sched_pkg.sv
      - hdl/request_queue.sv
      - hdl/bank_engine.sv
      - hdl/bank_array.sv
      - hdl/refresh_timer.sv
      - hdl/cmd_arbiter.sv
      - hdl/dram_sched_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/dram_sched_tb.sv

//--- dram_sched.f
+incdir+include
hdl/dram_sched_pkg.sv
hdl/request_queue.sv
hdl/bank_engine.sv
hdl/bank_array.sv
hdl/refresh_timer.sv
hdl/cmd_arbiter.sv
hdl/dram_sched_top.sv
tb/dram_sched_tb.sv

//--- hdl/bank_array.sv
`default_nettype none

`include "dram_sched_macros.svh"

module bank_array (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      head_valid,
	input  logic                      head_write,
	input  dram_sched_pkg::addr_t     head_addr,
	input  dram_sched_pkg::bg_t       last_bg,   // group of the last issued cmd
	input  logic [`NUM_BANKS-1:0]     grant,
	output logic                      pop,
	output logic [`NUM_BANKS-1:0]     ready,
	output dram_sched_pkg::dram_cmd_e issue_op [`NUM_BANKS],
	output dram_sched_pkg::row_t      issue_row [`NUM_BANKS],
	output dram_sched_pkg::col_t      issue_col [`NUM_BANKS]
);
	import dram_sched_pkg::*;

	row_t                         head_row;
	bg_t                          head_bg;
	bank_t                        head_bank;
	col_t                         head_col;
	logic [`BG_W+`BANK_W-1:0]     sel;       // engine index {bg, bank}
	logic [`NUM_BANKS-1:0]        idle;
	logic [`NUM_BANKS-1:0]        load;
	logic                         hit;
	logic                         same_bg;

	// row | bg | bank | col
	assign {head_row, head_bg, head_bank, head_col} = head_addr;
	assign sel = {head_bg, head_bank};

	assign pop     = head_valid && idle[sel]; // in order, head waits for its bank
	assign load    = pop ? (`NUM_BANKS'(1) << sel) : '0;
	assign hit     = (issue_row[sel] == head_row); // idle engine shows its open row
	assign same_bg = (head_bg == last_bg);

	for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
		bank_engine u_bank_engine (
			.clk          (clk),
			.rst_n        (rst_n),
			.load         (load[i]),
			.load_write   (head_write),
			.load_row     (head_row),
			.load_col     (head_col),
			.load_hit     (hit),
			.load_same_bg (same_bg),
			.grant        (grant[i]),
			.idle         (idle[i]),
			.ready        (ready[i]),
			.issue_op     (issue_op[i]),
			.open_row     (issue_row[i]),
			.issue_col    (issue_col[i])
		);
	end

endmodule

`default_nettype wire

//--- hdl/bank_engine.sv
`default_nettype none

`include "dram_sched_macros.svh"

module bank_engine (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      load,         // new request for this bank
	input  logic                      load_write,
	input  dram_sched_pkg::row_t      load_row,
	input  dram_sched_pkg::col_t      load_col,
	input  logic                      load_hit,     // target row already open
	input  logic                      load_same_bg, // same group as last issued cmd
	input  logic                      grant,
	output logic                      idle,
	output logic                      ready,
	output dram_sched_pkg::dram_cmd_e issue_op,
	output dram_sched_pkg::row_t      open_row,
	output dram_sched_pkg::col_t      issue_col
);
	import dram_sched_pkg::*;

	bank_op_e state;
	count_t   cnt;
	row_t     row_q;     // row currently open, 0 after reset counts as open
	logic     req_write; // pending request payload
	row_t     req_row;
	col_t     req_col;

	always_ff @(posedge clk) begin
		if (load) begin
			req_write <= load_write;
			req_row   <= load_row;
			req_col   <= load_col;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= NO_OP;
			cnt   <= '0;
			row_q <= '0;
		end else if (load) begin
			// countdown left over from the last burst keeps running in the wait state
			if (load_hit) state <= load_same_bg ? WAIT_CCD_L : WAIT_CCD_S;
			else          state <= load_same_bg ? WAIT_RRD_L : WAIT_RRD_S;
		end else if (state != NO_OP) begin
			if (cnt != '0) begin
				cnt <= cnt - 1'b1; // frozen while idle
			end else begin
				case (state)
					WAIT_CCD_L: begin state <= ISSUE_COL; cnt <= count_t'(`T_CCD_L); end
					WAIT_CCD_S: begin state <= ISSUE_COL; cnt <= count_t'(`T_CCD_S); end
					WAIT_RRD_L: begin state <= ISSUE_PRE; cnt <= count_t'(`T_RRD_L); end
					WAIT_RRD_S: begin state <= ISSUE_PRE; cnt <= count_t'(`T_RRD_S); end
					ISSUE_PRE: if (grant) begin
						state <= ISSUE_ACT;
						cnt   <= count_t'(`T_RP);
					end
					ISSUE_ACT: if (grant) begin
						state <= ISSUE_COL;
						cnt   <= count_t'(`T_RCD);
						row_q <= req_row; // new row now open
					end
					ISSUE_COL: if (grant) begin
						state <= NO_OP;
						cnt   <= count_t'(`T_CAS_BURST); // served by the next request
					end
					default: state <= NO_OP;
				endcase
			end
		end
	end

	assign idle  = (state == NO_OP);
	assign ready = (cnt == '0) && (state inside {ISSUE_PRE, ISSUE_ACT, ISSUE_COL});

	always_comb begin
		case (state)
			ISSUE_PRE: issue_op = PRE;
			ISSUE_ACT: issue_op = ACT;
			default:   issue_op = req_write ? WR : RD;
		endcase
	end

	// ACT carries the row being opened, everything else the open one
	assign open_row  = (state == ISSUE_ACT) ? req_row : row_q;
	assign issue_col = req_col;

endmodule

`default_nettype wire

//--- hdl/cmd_arbiter.sv
`default_nettype none

`include "dram_sched_macros.svh"

module cmd_arbiter (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      ref_due,
	input  logic                      ref_busy,
	input  logic [`NUM_BANKS-1:0]     ready,
	input  dram_sched_pkg::dram_cmd_e issue_op [`NUM_BANKS],
	input  dram_sched_pkg::row_t      issue_row [`NUM_BANKS],
	input  dram_sched_pkg::col_t      issue_col [`NUM_BANKS],
	output logic [`NUM_BANKS-1:0]     grant,     // one-hot
	output dram_sched_pkg::bg_t       last_bg,
	output logic                      cmd_valid,
	output dram_sched_pkg::dram_cmd_e cmd_op,
	output dram_sched_pkg::bg_t       cmd_bg,
	output dram_sched_pkg::bank_t     cmd_bank,
	output dram_sched_pkg::row_t      cmd_row,
	output dram_sched_pkg::col_t      cmd_col
);
	import dram_sched_pkg::*;

	logic [`BG_W+`BANK_W-1:0] sel;   // lowest ready bank
	logic                     found;
	logic                     take;  // a bank wins this cycle

	always_comb begin
		sel   = '0;
		found = 1'b0;
		for (int i = `NUM_BANKS - 1; i >= 0; i--) begin // last hit is lowest index
			if (ready[i]) begin
				sel   = i[`BG_W+`BANK_W-1:0];
				found = 1'b1;
			end
		end
	end

	assign take  = found && !ref_busy; // ref_due always comes with ref_busy
	assign grant = take ? (`NUM_BANKS'(1) << sel) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_valid <= 1'b0;
			last_bg   <= '0;
		end else begin
			cmd_valid <= ref_due || take;
			if (take) last_bg <= sel[`BG_W+`BANK_W-1:`BANK_W]; // REF leaves it alone
		end
	end

	always_ff @(posedge clk) begin
		if (ref_due) begin
			cmd_op   <= REF; // all banks, no address
			cmd_bg   <= '0;
			cmd_bank <= '0;
			cmd_row  <= '0;
			cmd_col  <= '0;
		end else if (take) begin
			cmd_op   <= issue_op[sel];
			cmd_bg   <= sel[`BG_W+`BANK_W-1:`BANK_W];
			cmd_bank <= sel[`BANK_W-1:0];
			cmd_row  <= issue_row[sel];
			cmd_col  <= issue_col[sel];
		end
	end

endmodule

`default_nettype wire

//--- hdl/dram_sched_pkg.sv
`default_nettype none

`include "dram_sched_macros.svh"

package dram_sched_pkg;

	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`ROW_W-1:0]  row_t;
	typedef logic [`BG_W-1:0]   bg_t;
	typedef logic [`BANK_W-1:0] bank_t;
	typedef logic [`COL_W-1:0]  col_t;

	typedef logic [4:0] count_t; // bank countdown, big enough for every wait

	// commands on the DRAM bus
	typedef enum logic [2:0] {RD, WR, ACT, PRE, REF} dram_cmd_e;

	// per-bank progress through one request
	typedef enum logic [2:0] {
		NO_OP,      // free for the next request
		WAIT_CCD_L, // row hit, long column spacing
		WAIT_CCD_S,
		WAIT_RRD_L, // row miss, long spacing before PRE
		WAIT_RRD_S,
		ISSUE_PRE,
		ISSUE_ACT,
		ISSUE_COL
	} bank_op_e;

endpackage

`default_nettype wire

//--- hdl/dram_sched_top.sv
`default_nettype none

`include "dram_sched_macros.svh"

module dram_sched_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      req_valid,
	input  logic                      req_write,
	input  dram_sched_pkg::addr_t     req_addr,
	output logic                      queue_full,
	output logic                      pending_request,
	output logic                      cmd_valid,
	output dram_sched_pkg::dram_cmd_e cmd_op,
	output dram_sched_pkg::bg_t       cmd_bg,
	output dram_sched_pkg::bank_t     cmd_bank,
	output dram_sched_pkg::row_t      cmd_row,
	output dram_sched_pkg::col_t      cmd_col
);
	import dram_sched_pkg::*;

	logic                  head_valid;
	logic                  head_write;
	addr_t                 head_addr;
	logic                  pop;
	logic [`NUM_BANKS-1:0] ready;
	logic [`NUM_BANKS-1:0] grant;
	dram_cmd_e             issue_op [`NUM_BANKS];
	row_t                  issue_row [`NUM_BANKS];
	col_t                  issue_col [`NUM_BANKS];
	bg_t                   last_bg;
	logic                  ref_due;
	logic                  ref_busy;

	request_queue u_request_queue (
		.clk (clk), .rst_n (rst_n),
		.req_valid (req_valid), .req_write (req_write), .req_addr (req_addr), .pop (pop),
		.head_valid (head_valid), .head_write (head_write), .head_addr (head_addr),
		.queue_full (queue_full), .pending_request (pending_request)
	);

	bank_array u_bank_array (
		.clk (clk), .rst_n (rst_n),
		.head_valid (head_valid), .head_write (head_write), .head_addr (head_addr),
		.last_bg (last_bg), .grant (grant), .pop (pop), .ready (ready),
		.issue_op (issue_op), .issue_row (issue_row), .issue_col (issue_col)
	);

	refresh_timer u_refresh_timer (
		.clk (clk), .rst_n (rst_n), .ref_due (ref_due), .ref_busy (ref_busy)
	);

	cmd_arbiter u_cmd_arbiter (
		.clk (clk), .rst_n (rst_n), .ref_due (ref_due), .ref_busy (ref_busy),
		.ready (ready), .issue_op (issue_op), .issue_row (issue_row), .issue_col (issue_col),
		.grant (grant), .last_bg (last_bg), .cmd_valid (cmd_valid), .cmd_op (cmd_op),
		.cmd_bg (cmd_bg), .cmd_bank (cmd_bank), .cmd_row (cmd_row), .cmd_col (cmd_col)
	);

endmodule

`default_nettype wire

//--- hdl/refresh_timer.sv
`default_nettype none

`include "dram_sched_macros.svh"

module refresh_timer (
	input  logic clk,
	input  logic rst_n,
	output logic ref_due,  // one cycle, REF goes out next
	output logic ref_busy  // bus closed to bank commands
);
	localparam int REFI_W = $clog2(`T_REFI + 1);
	localparam int RFC_W  = $clog2(`T_RFC + 1);

	logic [REFI_W-1:0] refi_cnt;
	logic [RFC_W-1:0]  rfc_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			refi_cnt <= REFI_W'(`T_REFI);
			rfc_cnt  <= RFC_W'(`T_RFC);
		end else if (refi_cnt != '0) begin
			refi_cnt <= refi_cnt - 1'b1; // interval running
		end else if (rfc_cnt != '0) begin
			rfc_cnt <= rfc_cnt - 1'b1;   // refresh in progress
		end else begin
			refi_cnt <= REFI_W'(`T_REFI); // done, start next interval
			rfc_cnt  <= RFC_W'(`T_RFC);
		end
	end

	// busy for the due cycle plus T_RFC more
	assign ref_busy = (refi_cnt == '0);
	assign ref_due  = ref_busy && (rfc_cnt == RFC_W'(`T_RFC));

endmodule

`default_nettype wire

//--- hdl/request_queue.sv
`default_nettype none

`include "dram_sched_macros.svh"

module request_queue (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req_valid,       // strobe from the parser
	input  logic                   req_write,
	input  dram_sched_pkg::addr_t  req_addr,
	input  logic                   pop,             // head taken by a bank
	output logic                   head_valid,
	output logic                   head_write,
	output dram_sched_pkg::addr_t  head_addr,
	output logic                   queue_full,
	output logic                   pending_request  // last offered request was dropped
);
	import dram_sched_pkg::*;

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);

	addr_t            mem_addr [`QUEUE_DEPTH]; // entry storage
	logic             mem_write [`QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic [PTR_W:0]   count_nxt;
	logic             push;

	// a full queue still takes a request when the head leaves on the same edge
	assign push = req_valid && (!queue_full || pop);

	always_comb begin
		case ({push, pop})
			2'b10:   count_nxt = count + 1'b1;
			2'b01:   count_nxt = count - 1'b1;
			default: count_nxt = count; // both or neither
		endcase
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem_addr[wr_ptr]  <= req_addr;
			mem_write[wr_ptr] <= req_write;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr          <= '0;
			rd_ptr          <= '0;
			count           <= '0;
			queue_full      <= 1'b0;
			pending_request <= 1'b0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop)  rd_ptr <= rd_ptr + 1'b1;
			count      <= count_nxt;
			queue_full <= (count_nxt == (PTR_W+1)'(`QUEUE_DEPTH));
			if (push)
				pending_request <= 1'b0; // cleared by any accepted request
			else if (req_valid)
				pending_request <= 1'b1; // refused, parser must offer again
		end
	end

	assign head_valid = (count != '0);
	assign head_addr  = mem_addr[rd_ptr];
	assign head_write = mem_write[rd_ptr];

endmodule

`default_nettype wire

//--- include/dram_sched_macros.svh
`ifndef DRAM_SCHED_MACROS_SVH
`define DRAM_SCHED_MACROS_SVH

// address fields, row on top, column in the low bits
`define ROW_W  8
`define BG_W   2
`define BANK_W 2
`define COL_W  4
`define ADDR_W 16

`define NUM_BANKS (1 << (`BG_W + `BANK_W)) // one engine per bank group/bank pair

`define QUEUE_DEPTH 8 // power of two, pointers wrap on their own

// DRAM timing, in clk cycles
`define T_RCD       4 // ACT to RD/WR
`define T_RP        4 // PRE to ACT
`define T_CAS_BURST 6 // column cmd until the bank takes a new request
`define T_CCD_L     3 // column spacing, same bank group
`define T_CCD_S     2 // column spacing, other group
`define T_RRD_L     3 // spacing before PRE, same group
`define T_RRD_S     2
`define T_REFI      200
`define T_RFC       20
`define REF_PERIOD  (`T_REFI + `T_RFC + 1) // cycles from one REF to the next

`endif

//--- tb/dram_sched_tb.sv
`default_nettype none

`include "dram_sched_macros.svh"

module dram_sched_tb;
	import dram_sched_pkg::*;

	localparam int STIM_CYCLES    = 300 + 120 + 400; // sparse + burst + mix
	localparam int DRAIN_CYCLES   = `REF_PERIOD * 4; // enough for a full queue on one bank
	localparam int TIMEOUT_CYCLES = `REF_PERIOD * 8 + STIM_CYCLES;

	logic      clk;
	logic      rst_n;
	logic      req_valid;
	logic      req_write;
	addr_t     req_addr;
	logic      queue_full;
	logic      pending_request;
	logic      cmd_valid;
	dram_cmd_e cmd_op;
	bg_t       cmd_bg;
	bank_t     cmd_bank;
	row_t      cmd_row;
	col_t      cmd_col;

	// reference model
	logic [`ADDR_W:0] pend [`NUM_BANKS][$]; // {write, addr} per bank, in order
	int               stage [`NUM_BANKS];    // 0 start, 1 PRE seen, 2 ACT seen
	row_t             open_row [`NUM_BANKS];
	int               pre_time [`NUM_BANKS];
	int               act_time [`NUM_BANKS];
	logic             model_pending;
	int               outstanding;
	int               cycle;
	int               next_ref;
	int               last_ref;
	int               wd_cycles;
	int               drain_cycles;

	logic             offered;      // request driven at the last falling edge
	logic             offered_full; // queue_full seen when it was driven
	logic [`ADDR_W:0] offered_word;

	int checks [5];
	int errs [5];
	int n_accepted;
	int n_refused;
	int n_ref;
	int total_err;

	dram_sched_top u_dram_sched_top (
		.clk             (clk),
		.rst_n           (rst_n),
		.req_valid       (req_valid),
		.req_write       (req_write),
		.req_addr        (req_addr),
		.queue_full      (queue_full),
		.pending_request (pending_request),
		.cmd_valid       (cmd_valid),
		.cmd_op          (cmd_op),
		.cmd_bg          (cmd_bg),
		.cmd_bank        (cmd_bank),
		.cmd_row         (cmd_row),
		.cmd_col         (cmd_col)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic compare_value(int beh, string name, logic [31:0] got, logic [31:0] exp);
		checks[beh]++;
		assert (got === exp) else begin
			$display("CHECK FAILED %s got %h expected %h at cycle %0d", name, got, exp, cycle);
			errs[beh]++;
		end
	endtask

	task automatic require(int beh, bit ok, string what);
		checks[beh]++;
		assert (ok) else begin
			$display("%s at cycle %0d", what, cycle);
			errs[beh]++;
		end
	endtask

	// outcome of the request offered one cycle ago
	task automatic record_offer();
		logic accepted;
		int   b;
		b = int'(offered_word[`COL_W +: `BG_W + `BANK_W]);
		if (!offered_full) begin
			compare_value(0, "pending_request", pending_request, 0); // room left so it must be taken
			accepted = 1'b1;
		end else begin
			accepted = !pending_request; // when full only a same-edge pop lets it in
		end
		if (accepted) begin
			pend[b].push_back(offered_word);
			outstanding++;
			n_accepted++;
		end else begin
			n_refused++; // kept out of the model so a served copy breaks the order check
		end
		model_pending = !accepted;
	endtask

	task automatic handle_command();
		int               b;
		logic [`ADDR_W:0] word;
		logic             w;
		row_t             r;
		col_t             c;
		require(4, !$isunknown(cmd_op), "command bus carries an unknown opcode");
		if (cmd_op == REF) begin
			require(3, cycle == next_ref, "REF outside its refresh slot");
			last_ref = cycle;
			next_ref = cycle + `REF_PERIOD;
			n_ref++;
		end else begin
			require(3, cycle - last_ref > `T_RFC, "bank command inside the refresh window");
			b = int'({cmd_bg, cmd_bank});
			if (pend[b].size() == 0) begin
				require(1, 1'b0, "command for a bank with no accepted request");
			end else begin
				word = pend[b][0];
				w    = word[`ADDR_W];
				r    = word[`ADDR_W-1 -: `ROW_W];
				c    = word[`COL_W-1:0];
				if (stage[b] == 1) begin
					compare_value(1, "cmd_op", 32'(cmd_op), 32'(ACT));
					compare_value(1, "cmd_row", cmd_row, r); // new row
					require(2, cycle - pre_time[b] >= `T_RP, "ACT too soon after PRE");
					stage[b]    = 2;
					open_row[b] = r;
					act_time[b] = cycle;
				end else if (stage[b] == 0 && r != open_row[b]) begin
					compare_value(1, "cmd_op", 32'(cmd_op), 32'(PRE)); // row miss
					compare_value(1, "cmd_row", cmd_row, open_row[b]);
					stage[b]    = 1;
					pre_time[b] = cycle;
				end else begin
					compare_value(1, "cmd_op", 32'(cmd_op), w ? 32'(WR) : 32'(RD));
					compare_value(1, "cmd_row", cmd_row, r);
					compare_value(1, "cmd_col", cmd_col, c);
					if (stage[b] == 2)
						require(2, cycle - act_time[b] >= `T_RCD,
							"column command too soon after ACT");
					stage[b] = 0;
					void'(pend[b].pop_front());
					outstanding--;
				end
			end
		end
	endtask

	// each falling edge checks what the last rising edge produced
	task automatic tick();
		@(negedge clk);
		cycle++;
		if (offered)
			record_offer();
		else
			compare_value(0, "pending_request", pending_request, model_pending); // held
		if (cycle == next_ref && !(cmd_valid && cmd_op == REF)) begin
			require(3, 1'b0, "no REF at its refresh slot");
			next_ref = cycle + `REF_PERIOD;
		end
		if (cmd_valid) handle_command();
		if (queue_full)
			require(0, outstanding >= `QUEUE_DEPTH,
				"queue_full high with fewer accepted requests than the queue holds");
	endtask

	task automatic drive_request(bit on, bit narrow);
		row_t  r;
		bg_t   g;
		bank_t k;
		col_t  c;
		offered   = on;
		req_valid = on;
		if (on) begin
			r            = row_t'($urandom_range(2, 0)); // few rows give hits and misses
			g            = narrow ? bg_t'(0) : bg_t'($urandom);
			k            = narrow ? bank_t'($urandom_range(1, 0)) : bank_t'($urandom);
			c            = col_t'($urandom);
			req_write    = $urandom_range(1, 0);
			req_addr     = {r, g, k, c};
			offered_full = queue_full;
			offered_word = {req_write, req_addr};
		end
	endtask

	task automatic run_phase(int cycles, int rate, bit narrow);
		for (int i = 0; i < cycles; i++) begin
			tick();
			drive_request($urandom_range(rate - 1, 0) == 0, narrow);
		end
	endtask

	task automatic report();
		string names [5];
		names = '{"queue full and pending flag", "per-bank command order",
			"PRE/ACT/column spacing", "refresh slots and window", "bus use and completion"};
		for (int i = 0; i < 5; i++)
			$display("%-28s %5d checks %3d errors %s", names[i], checks[i], errs[i],
				errs[i] == 0 ? "ok" : "BAD");
	endtask

	// watchdog sized from the stimulus plus eight refresh periods
	initial begin
		wd_cycles = 0;
		while (wd_cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			wd_cycles++;
		end
		$display("run timed out after %0d cycles with %0d requests unserved",
			wd_cycles, outstanding);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'ha5a9_37f7));
		rst_n        = 1'b0;
		req_valid    = 1'b0;
		req_write    = 1'b0;
		req_addr     = '0;
		offered      = 1'b0;
		offered_full = 1'b0;
		offered_word = '0;
		model_pending = 1'b0;
		outstanding  = 0;
		cycle        = 0;
		drain_cycles = 0;
		next_ref     = `T_REFI + 1; // first REF after release
		last_ref     = -1000;
		n_accepted   = 0;
		n_refused    = 0;
		n_ref        = 0;
		for (int i = 0; i < 5; i++) begin
			checks[i] = 0;
			errs[i]   = 0;
		end
		for (int b = 0; b < `NUM_BANKS; b++) begin
			stage[b]    = 0;
			open_row[b] = '0; // row 0 counts as open after reset
			pre_time[b] = 0;
			act_time[b] = 0;
		end
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		compare_value(4, "cmd_valid", cmd_valid, 0);
		compare_value(0, "queue_full", queue_full, 0);
		compare_value(0, "pending_request", pending_request, 0);

		run_phase(300, 8, 1'b0); // sparse
		run_phase(120, 1, 1'b1); // burst on two banks fills the queue
		require(0, n_refused > 0, "queue never refused a request during the burst");
		run_phase(400, 2, 1'b0); // random mix
		while (outstanding != 0 && drain_cycles < DRAIN_CYCLES) begin // drain
			tick();
			drive_request(1'b0, 1'b0);
			drain_cycles++;
		end
		compare_value(4, "outstanding requests", outstanding, 0);
		repeat (40) begin // idle tail, any late command is unexpected
			tick();
			drive_request(1'b0, 1'b0);
		end

		report();
		total_err = 0;
		for (int i = 0; i < 5; i++) total_err += errs[i];
		$display("total checks %0d errors %0d accepted %0d refused %0d REF %0d",
			checks[0] + checks[1] + checks[2] + checks[3] + checks[4], total_err,
			n_accepted, n_refused, n_ref);
		if (total_err == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
